/* design/dual_issue_config.svh */
`ifndef DUAL_ISSUE_CONFIG_SVH
`define DUAL_ISSUE_CONFIG_SVH

// Issue queue entries, a power of two and at least 4
`define DUAL_ISSUE_DEPTH 8

// Program counter width
`define DUAL_ISSUE_XLEN 32

// Raw instruction word width
`define DUAL_ISSUE_INSTR_WIDTH 32

`endif

/* design/dual_issue_pkg.sv */
`default_nettype none

package dual_issue_pkg;

  typedef enum logic [3:0] {
    class_alu     = 4'd0,
    class_load    = 4'd1,
    class_store   = 4'd2,
    class_branch  = 4'd3,
    class_jump    = 4'd4,
    class_muldiv  = 4'd5,
    class_csr     = 4'd6,
    class_fence   = 4'd7,
    class_system  = 4'd8,
    class_illegal = 4'd9
  } op_class_t;

  // Major opcodes, instruction bits 6:0
  typedef enum logic [6:0] {
    op       = 7'b0110011,
    op_imm   = 7'b0010011,
    lui      = 7'b0110111,
    auipc    = 7'b0010111,
    jal      = 7'b1101111,
    jalr     = 7'b1100111,
    branch   = 7'b1100011,
    load     = 7'b0000011,
    store    = 7'b0100011,
    misc_mem = 7'b0001111,
    system   = 7'b1110011
  } opcode_t;

endpackage

`default_nettype wire

/* design/instruction_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dual_issue_config.svh"

module instruction_decoder (
  input  logic [`DUAL_ISSUE_INSTR_WIDTH-1:0] instr,
  output dual_issue_pkg::op_class_t op_class,
  output logic [4:0] rd,
  output logic [4:0] rs1,
  output logic [4:0] rs2,
  output logic rden1,
  output logic rden2,
  output logic wren
);
  import dual_issue_pkg::*;

  opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic writes;  // Format has a destination register

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign wren = writes && (rd != 5'd0);  // Writes to x0 are discarded

  always_comb begin
    op_class = class_illegal;
    rden1 = 1'b0;
    rden2 = 1'b0;
    writes = 1'b0;
    case (opcode)
      op: begin
        rden1 = 1'b1;
        rden2 = 1'b1;
        writes = 1'b1;
        if (funct7 == 7'b0000001) begin
          op_class = class_muldiv;  // M extension
        end else if (funct7 == 7'b0000000) begin
          op_class = class_alu;
        end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          op_class = class_alu;  // sub and sra
        end
      end
      op_imm: begin
        rden1 = 1'b1;
        writes = 1'b1;
        if (funct3 == 3'b001) begin
          op_class = (funct7 == 7'b0000000) ? class_alu : class_illegal;
        end else if (funct3 == 3'b101) begin
          if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
            op_class = class_alu;
          end
        end else begin
          op_class = class_alu;
        end
      end
      lui, auipc: begin
        writes = 1'b1;
        op_class = class_alu;
      end
      jal: begin
        writes = 1'b1;
        op_class = class_jump;
      end
      jalr: begin
        rden1 = 1'b1;
        writes = 1'b1;
        if (funct3 == 3'b000) begin
          op_class = class_jump;
        end
      end
      branch: begin
        rden1 = 1'b1;
        rden2 = 1'b1;
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          op_class = class_branch;
        end
      end
      load: begin
        rden1 = 1'b1;
        writes = 1'b1;
        if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
          op_class = class_load;
        end
      end
      store: begin
        rden1 = 1'b1;
        rden2 = 1'b1;
        if (funct3[2] == 1'b0 && funct3 != 3'b011) begin
          op_class = class_store;
        end
      end
      misc_mem: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          op_class = class_fence;  // fence and fence.i
        end
      end
      system: begin
        if (funct3 == 3'b000) begin
          // Only ecall, ebreak, mret and wfi are known
          if (instr == 32'h00000073 || instr == 32'h00100073 ||
              instr == 32'h30200073 || instr == 32'h10500073) begin
            op_class = class_system;
          end
        end else if (funct3 != 3'b100) begin
          writes = 1'b1;
          rden1 = !funct3[2];  // Immediate forms carry zimm in rs1
          op_class = class_csr;
        end
      end
      default: begin
        op_class = class_illegal;
      end
    endcase
    if (op_class == class_illegal) begin
      rden1 = 1'b0;
      rden2 = 1'b0;
      writes = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/issue_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dual_issue_config.svh"

module issue_buffer (
  input  logic clock,
  input  logic reset,
  input  logic flush,
  input  logic fetch_valid0,
  input  logic fetch_valid1,
  output logic fetch_ready,
  input  logic [`DUAL_ISSUE_XLEN-1:0] fetch_pc0,
  input  logic [`DUAL_ISSUE_INSTR_WIDTH-1:0] fetch_instr0,
  input  dual_issue_pkg::op_class_t dec_class0,
  input  logic [4:0] dec_rd0,
  input  logic [4:0] dec_rs1_0,
  input  logic [4:0] dec_rs2_0,
  input  logic dec_rden1_0,
  input  logic dec_rden2_0,
  input  logic dec_wren0,
  input  logic [`DUAL_ISSUE_XLEN-1:0] fetch_pc1,
  input  logic [`DUAL_ISSUE_INSTR_WIDTH-1:0] fetch_instr1,
  input  dual_issue_pkg::op_class_t dec_class1,
  input  logic [4:0] dec_rd1,
  input  logic [4:0] dec_rs1_1,
  input  logic [4:0] dec_rs2_1,
  input  logic dec_rden1_1,
  input  logic dec_rden2_1,
  input  logic dec_wren1,
  output logic issue_valid0,
  output logic issue_valid1,
  input  logic issue_ready,
  output logic [`DUAL_ISSUE_XLEN-1:0] issue_pc0,
  output logic [`DUAL_ISSUE_INSTR_WIDTH-1:0] issue_instr0,
  output dual_issue_pkg::op_class_t issue_class0,
  output logic [4:0] issue_rd0,
  output logic [4:0] issue_rs1_0,
  output logic [4:0] issue_rs2_0,
  output logic issue_wren0,
  output logic [`DUAL_ISSUE_XLEN-1:0] issue_pc1,
  output logic [`DUAL_ISSUE_INSTR_WIDTH-1:0] issue_instr1,
  output dual_issue_pkg::op_class_t issue_class1,
  output logic [4:0] issue_rd1,
  output logic [4:0] issue_rs1_1,
  output logic [4:0] issue_rs2_1,
  output logic issue_wren1
);
  import dual_issue_pkg::*;

  localparam int depth = `DUAL_ISSUE_DEPTH;
  localparam int ptr_width = $clog2(depth);
  localparam logic [ptr_width:0] fill_limit = (ptr_width + 1)'(depth - 2);

  typedef struct packed {
    logic [`DUAL_ISSUE_XLEN-1:0] pc;
    logic [`DUAL_ISSUE_INSTR_WIDTH-1:0] instr;
    op_class_t op_class;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic rden1;
    logic rden2;
    logic wren;
  } entry_t;

  entry_t entries [depth];
  entry_t slot0;
  entry_t slot1;
  entry_t head0;
  entry_t head1;
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] wr_ptr1;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width-1:0] rd_ptr1;
  logic [ptr_width:0] count;
  logic [ptr_width:0] push_count;
  logic [ptr_width:0] pop_count;
  logic push0;
  logic push1;
  logic single;
  logic shared_unit;
  logic raw_hazard;

  function automatic logic issues_alone(input op_class_t op_class);
    return op_class == class_fence || op_class == class_system || op_class == class_illegal;
  endfunction

  function automatic logic is_memory(input op_class_t op_class);
    return op_class == class_load || op_class == class_store;
  endfunction

  assign slot0 = '{pc: fetch_pc0, instr: fetch_instr0, op_class: dec_class0, rd: dec_rd0,
                   rs1: dec_rs1_0, rs2: dec_rs2_0, rden1: dec_rden1_0, rden2: dec_rden2_0,
                   wren: dec_wren0};
  assign slot1 = '{pc: fetch_pc1, instr: fetch_instr1, op_class: dec_class1, rd: dec_rd1,
                   rs1: dec_rs1_1, rs2: dec_rs2_1, rden1: dec_rden1_1, rden2: dec_rden2_1,
                   wren: dec_wren1};

  // Room for a full pair, taken from the registered count only
  assign fetch_ready = count <= fill_limit;

  assign push0 = fetch_valid0 && fetch_ready && !flush;
  assign push1 = fetch_valid1 && fetch_ready && !flush;
  assign push_count = (ptr_width + 1)'(push0) + (ptr_width + 1)'(push1);
  assign wr_ptr1 = wr_ptr + ptr_width'(push0);  // Slot 1 lands behind slot 0

  assign rd_ptr1 = rd_ptr + ptr_width'(1);
  assign head0 = entries[rd_ptr];
  assign head1 = entries[rd_ptr1];

  assign single = issues_alone(head0.op_class) || issues_alone(head1.op_class);
  assign shared_unit = (is_memory(head0.op_class) && is_memory(head1.op_class)) ||
                       (head0.op_class == class_muldiv && head1.op_class == class_muldiv) ||
                       (head0.op_class == class_csr && head1.op_class == class_csr);
  assign raw_hazard = head0.wren && ((head1.rden1 && head1.rs1 == head0.rd) ||
                                     (head1.rden2 && head1.rs2 == head0.rd));

  assign issue_valid0 = count != '0;
  assign issue_valid1 = (count > (ptr_width + 1)'(1)) && !single && !shared_unit && !raw_hazard;
  assign pop_count = issue_ready ?
                     (ptr_width + 1)'(issue_valid0) + (ptr_width + 1)'(issue_valid1) : '0;

  assign issue_pc0 = head0.pc;
  assign issue_instr0 = head0.instr;
  assign issue_class0 = head0.op_class;
  assign issue_rd0 = head0.rd;
  assign issue_rs1_0 = head0.rs1;
  assign issue_rs2_0 = head0.rs2;
  assign issue_wren0 = head0.wren;
  assign issue_pc1 = head1.pc;
  assign issue_instr1 = head1.instr;
  assign issue_class1 = head1.op_class;
  assign issue_rd1 = head1.rd;
  assign issue_rs1_1 = head1.rs1;
  assign issue_rs2_1 = head1.rs2;
  assign issue_wren1 = head1.wren;

  always_ff @(posedge clock) begin
    if (push0) begin
      entries[wr_ptr] <= slot0;
    end
    if (push1) begin
      entries[wr_ptr1] <= slot1;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      wr_ptr <= wr_ptr + push_count[ptr_width-1:0];
      rd_ptr <= rd_ptr + pop_count[ptr_width-1:0];
      count <= count + push_count - pop_count;
    end
  end

endmodule

`default_nettype wire

/* design/dual_issue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dual_issue_config.svh"

module dual_issue (
  input  logic clock,
  input  logic reset,
  input  logic flush,
  input  logic fetch_valid0,
  input  logic fetch_valid1,
  input  logic [`DUAL_ISSUE_XLEN-1:0] fetch_pc0,
  input  logic [`DUAL_ISSUE_XLEN-1:0] fetch_pc1,
  input  logic [`DUAL_ISSUE_INSTR_WIDTH-1:0] fetch_instr0,
  input  logic [`DUAL_ISSUE_INSTR_WIDTH-1:0] fetch_instr1,
  output logic fetch_ready,
  output logic issue_valid0,
  output logic issue_valid1,
  input  logic issue_ready,
  output logic [`DUAL_ISSUE_XLEN-1:0] issue_pc0,
  output logic [`DUAL_ISSUE_XLEN-1:0] issue_pc1,
  output logic [`DUAL_ISSUE_INSTR_WIDTH-1:0] issue_instr0,
  output logic [`DUAL_ISSUE_INSTR_WIDTH-1:0] issue_instr1,
  output dual_issue_pkg::op_class_t issue_class0,
  output dual_issue_pkg::op_class_t issue_class1,
  output logic [4:0] issue_rd0,
  output logic [4:0] issue_rd1,
  output logic [4:0] issue_rs1_0,
  output logic [4:0] issue_rs1_1,
  output logic [4:0] issue_rs2_0,
  output logic [4:0] issue_rs2_1,
  output logic issue_wren0,
  output logic issue_wren1
);
  import dual_issue_pkg::*;

  op_class_t dec_class0;
  op_class_t dec_class1;
  logic [4:0] dec_rd0;
  logic [4:0] dec_rd1;
  logic [4:0] dec_rs1_0;
  logic [4:0] dec_rs1_1;
  logic [4:0] dec_rs2_0;
  logic [4:0] dec_rs2_1;
  logic dec_rden1_0;
  logic dec_rden1_1;
  logic dec_rden2_0;
  logic dec_rden2_1;
  logic dec_wren0;
  logic dec_wren1;

  instruction_decoder i_decoder0 (
    .instr(fetch_instr0), .op_class(dec_class0),
    .rd(dec_rd0), .rs1(dec_rs1_0), .rs2(dec_rs2_0),
    .rden1(dec_rden1_0), .rden2(dec_rden2_0), .wren(dec_wren0)
  );

  instruction_decoder i_decoder1 (
    .instr(fetch_instr1), .op_class(dec_class1),
    .rd(dec_rd1), .rs1(dec_rs1_1), .rs2(dec_rs2_1),
    .rden1(dec_rden1_1), .rden2(dec_rden2_1), .wren(dec_wren1)
  );

  // Fetch valids and ready go straight to the queue
  issue_buffer i_issue_buffer (
    .clock(clock), .reset(reset), .flush(flush),
    .fetch_valid0(fetch_valid0), .fetch_valid1(fetch_valid1), .fetch_ready(fetch_ready),
    .fetch_pc0(fetch_pc0), .fetch_instr0(fetch_instr0), .dec_class0(dec_class0),
    .dec_rd0(dec_rd0), .dec_rs1_0(dec_rs1_0), .dec_rs2_0(dec_rs2_0),
    .dec_rden1_0(dec_rden1_0), .dec_rden2_0(dec_rden2_0), .dec_wren0(dec_wren0),
    .fetch_pc1(fetch_pc1), .fetch_instr1(fetch_instr1), .dec_class1(dec_class1),
    .dec_rd1(dec_rd1), .dec_rs1_1(dec_rs1_1), .dec_rs2_1(dec_rs2_1),
    .dec_rden1_1(dec_rden1_1), .dec_rden2_1(dec_rden2_1), .dec_wren1(dec_wren1),
    .issue_valid0(issue_valid0), .issue_valid1(issue_valid1), .issue_ready(issue_ready),
    .issue_pc0(issue_pc0), .issue_instr0(issue_instr0), .issue_class0(issue_class0),
    .issue_rd0(issue_rd0), .issue_rs1_0(issue_rs1_0), .issue_rs2_0(issue_rs2_0),
    .issue_wren0(issue_wren0),
    .issue_pc1(issue_pc1), .issue_instr1(issue_instr1), .issue_class1(issue_class1),
    .issue_rd1(issue_rd1), .issue_rs1_1(issue_rs1_1), .issue_rs2_1(issue_rs2_1),
    .issue_wren1(issue_wren1)
  );

endmodule

`default_nettype wire

/* verification/clock_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_generator (
  output logic clock,
  output logic reset
);
  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;  // 100 ns period
  end

  initial begin
    reset = 1'b0;
    repeat (2) @(posedge clock);
    #1 reset = 1'b1;  // Released just after the second edge
  end

endmodule

`default_nettype wire

/* verification/dual_issue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dual_issue_config.svh"

module dual_issue_tb;
  import dual_issue_pkg::*;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    op_class_t op_class;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic rden1;
    logic rden2;
    logic wren;
  } ref_entry_t;

  logic clock, reset, flush, fetch_ready, issue_ready;
  logic fetch_valid0, fetch_valid1, issue_valid0, issue_valid1;
  logic [31:0] fetch_pc0, fetch_pc1, fetch_instr0, fetch_instr1;
  logic [31:0] issue_pc0, issue_pc1, issue_instr0, issue_instr1;
  op_class_t issue_class0, issue_class1;
  logic [4:0] issue_rd0, issue_rd1, issue_rs1_0, issue_rs1_1, issue_rs2_0, issue_rs2_1;
  logic issue_wren0, issue_wren1;

  ref_entry_t model[$];  // Reference queue in program order
  ref_entry_t offer0, offer1;
  logic [31:0] next_pc;
  logic prev_stall, prev_valid0, prev_valid1;
  logic [31:0] prev_pc0, prev_instr0, prev_pc1, prev_instr1;
  int cycles;

  clock_generator i_clock_generator (.clock(clock), .reset(reset));

  dual_issue i_dual_issue (.*);

  task automatic fail_check(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // Builds one instruction of the given kind and its expected decode
  function automatic ref_entry_t build_instr(input int kind, input logic [31:0] pc);
    ref_entry_t e;
    logic [4:0] rd, rs1, rs2;
    rd = 5'($urandom_range(0, 3));
    rs1 = 5'($urandom_range(0, 3));
    rs2 = 5'($urandom_range(0, 3));
    if (kind == 11) begin
      rd = 5'd0;  // ecall has every register field zero
      rs1 = 5'd0;
      rs2 = 5'd0;
    end
    e = '0;
    e.pc = pc;
    case (kind)
      0: e.instr = {($urandom_range(0, 1) != 0) ? 7'h20 : 7'h00, rs2, rs1, 3'b000, rd, op};
      1: e.instr = {7'($urandom), rs2, rs1, 3'b000, rd, op_imm};
      2: e.instr = {7'($urandom), rs2, rs1, 3'($urandom), rd, lui};
      3: e.instr = {7'h00, rs2, rs1, 3'b010, rd, load};
      4: e.instr = {7'h00, rs2, rs1, 3'b010, rd, store};
      5: e.instr = {7'h00, rs2, rs1, 3'b000, rd, branch};
      6: e.instr = {7'($urandom), rs2, rs1, 3'($urandom), rd, jal};
      7: e.instr = {7'h00, rs2, rs1, 3'b000, rd, jalr};
      8: e.instr = {7'h01, rs2, rs1, 3'($urandom_range(0, 7)), rd, op};
      9: e.instr = {7'h30, rs2, rs1, 3'b001, rd, system};
      10: e.instr = {7'h00, rs2, rs1, 3'b000, rd, misc_mem};
      11: e.instr = 32'h00000073;
      default: e.instr = {7'h00, rs2, rs1, 3'b000, rd, 7'h7f};  // No such major opcode
    endcase
    e.rd = rd;
    e.rs1 = rs1;
    e.rs2 = rs2;
    case (kind)
      0, 1, 2: e.op_class = class_alu;
      3: e.op_class = class_load;
      4: e.op_class = class_store;
      5: e.op_class = class_branch;
      6, 7: e.op_class = class_jump;
      8: e.op_class = class_muldiv;
      9: e.op_class = class_csr;
      10: e.op_class = class_fence;
      11: e.op_class = class_system;
      default: e.op_class = class_illegal;
    endcase
    e.rden1 = kind == 0 || kind == 1 || kind == 3 || kind == 4 || kind == 5 ||
              kind == 7 || kind == 8 || kind == 9;
    e.rden2 = kind == 0 || kind == 4 || kind == 5 || kind == 8;
    e.wren = (kind <= 3 || kind == 6 || kind == 7 || kind == 8 || kind == 9) && e.rd != 5'd0;
    return e;
  endfunction

  function automatic logic pair_ok(input ref_entry_t a, input ref_entry_t b);
    logic alone, unit, hazard;
    alone = a.op_class inside {class_fence, class_system, class_illegal} ||
            b.op_class inside {class_fence, class_system, class_illegal};
    unit = (a.op_class inside {class_load, class_store} &&
            b.op_class inside {class_load, class_store}) ||
           (a.op_class == class_muldiv && b.op_class == class_muldiv) ||
           (a.op_class == class_csr && b.op_class == class_csr);
    hazard = a.wren && ((b.rden1 && b.rs1 == a.rd) || (b.rden2 && b.rs2 == a.rd));
    return !alone && !unit && !hazard;
  endfunction

  task automatic check_slot(input int slot, input ref_entry_t e, input logic [31:0] pc,
                            input logic [31:0] instr, input op_class_t op_class,
                            input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic wren);
    assert (pc == e.pc && instr == e.instr)
      else fail_check($sformatf("slot %0d issued pc %h instr %h, expected pc %h instr %h",
                                slot, pc, instr, e.pc, e.instr));
    assert (op_class == e.op_class && rd == e.rd && rs1 == e.rs1 && rs2 == e.rs2 &&
            wren == e.wren)
      else fail_check($sformatf("slot %0d decode of %h is class %0d wren %b, expected %0d %b",
                                slot, instr, op_class, wren, e.op_class, e.wren));
  endtask

  task automatic check_outputs();
    logic expect_pair;
    expect_pair = model.size() >= 2 && pair_ok(model[0], model[1]);
    assert (issue_valid0 == (model.size() != 0))
      else fail_check($sformatf("issue_valid0 is %b with %0d queued", issue_valid0, model.size()));
    assert (issue_valid1 == expect_pair)
      else fail_check($sformatf("issue_valid1 is %b, expected %b", issue_valid1, expect_pair));
    if (model.size() != 0) begin
      check_slot(0, model[0], issue_pc0, issue_instr0, issue_class0, issue_rd0,
                 issue_rs1_0, issue_rs2_0, issue_wren0);
    end
    if (expect_pair) begin
      check_slot(1, model[1], issue_pc1, issue_instr1, issue_class1, issue_rd1,
                 issue_rs1_1, issue_rs2_1, issue_wren1);
    end
    assert (fetch_ready == (model.size() <= `DUAL_ISSUE_DEPTH - 2))
      else fail_check($sformatf("fetch_ready is %b with %0d queued", fetch_ready, model.size()));
    if (prev_stall && prev_valid0) begin
      assert (issue_valid0 && issue_pc0 == prev_pc0 && issue_instr0 == prev_instr0)
        else fail_check("slot 0 changed while issue_ready was low");
    end
    if (prev_stall && prev_valid1) begin
      assert (issue_valid1 && issue_pc1 == prev_pc1 && issue_instr1 == prev_instr1)
        else fail_check("slot 1 changed while issue_ready was low");
    end
    prev_stall = !issue_ready && !flush;
    prev_valid0 = issue_valid0;
    prev_valid1 = issue_valid1;
    prev_pc0 = issue_pc0;
    prev_instr0 = issue_instr0;
    prev_pc1 = issue_pc1;
    prev_instr1 = issue_instr1;
  endtask

  // Applies the effect of the coming edge to the reference queue
  task automatic update_model();
    logic room;
    int pops;
    room = model.size() <= `DUAL_ISSUE_DEPTH - 2;
    pops = 0;
    if (issue_ready && model.size() != 0) begin
      pops = (model.size() >= 2 && pair_ok(model[0], model[1])) ? 2 : 1;
    end
    if (flush) begin
      model.delete();
    end else begin
      repeat (pops) void'(model.pop_front());
      if (fetch_valid0 && room) model.push_back(offer0);
      if (fetch_valid1 && room) model.push_back(offer1);
    end
  endtask

  task automatic run_cycle(input int valid_pct, input int ready_pct, input int flush_pct);
    @(posedge clock);
    #1;
    offer0 = build_instr($urandom_range(0, 12), next_pc);
    offer1 = build_instr($urandom_range(0, 12), next_pc + 32'd4);
    next_pc = next_pc + 32'd8;
    fetch_valid0 = $urandom_range(0, 99) < valid_pct;
    fetch_valid1 = fetch_valid0 && $urandom_range(0, 99) < 70;
    fetch_pc0 = offer0.pc;
    fetch_instr0 = offer0.instr;
    fetch_pc1 = offer1.pc;
    fetch_instr1 = offer1.instr;
    issue_ready = $urandom_range(0, 99) < ready_pct;
    flush = $urandom_range(0, 99) < flush_pct;
    @(negedge clock);
    check_outputs();
    update_model();
  endtask

  initial begin
    void'($urandom(32'h87c8e6f0));
    flush = 1'b0;
    fetch_valid0 = 1'b0;
    fetch_valid1 = 1'b0;
    fetch_pc0 = '0;
    fetch_pc1 = '0;
    fetch_instr0 = '0;
    fetch_instr1 = '0;
    issue_ready = 1'b0;
    next_pc = 32'h1000;
    prev_stall = 1'b0;
    cycles = 0;
    while (reset !== 1'b1) begin
      @(negedge clock);
      cycles++;
      if (cycles > 10) fail_check("reset was never released");
    end
    assert (!issue_valid0 && !issue_valid1 && fetch_ready)
      else fail_check("issue or fetch handshake wrong in the first cycle after reset");
    repeat (300) run_cycle(80, 75, 0);
    repeat (15) run_cycle(100, 0, 0);  // Queue fills under back-pressure
    repeat (300) run_cycle(70, 70, 4);
    cycles = 0;
    while (model.size() != 0) begin
      run_cycle(0, 100, 0);
      cycles++;
      if (cycles > 40) fail_check("queue did not drain");
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* dual_issue.f */
+incdir+design
design/dual_issue_pkg.sv
design/instruction_decoder.sv
design/issue_buffer.sv
design/dual_issue.sv
verification/clock_generator.sv
verification/dual_issue_tb.sv

/* Makefile */
# Verilator build and run of the dual-issue testbench

TOP := dual_issue_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove build products"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -Wall -f dual_issue.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); status=$$?; echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$" && [ $$status -eq 0 ]

clean:
	rm -rf obj_dir
